/* list.f */
+incdir+hw
+incdir+bench
hw/axi_rd_pkg.sv
hw/ar_alloc.sv
hw/burst_addr_gen.sv
hw/rd_slot.sv
hw/r_return.sv
hw/axi_rd_slave.sv
bench/tb_axi_rd_slave.sv

/* bench/tb_axi_rd_model.svh */
`ifndef TB_AXI_RD_MODEL_SVH
`define TB_AXI_RD_MODEL_SVH

`include "axi_rd_defines.svh"

// --------------------------------------------------
// Stimulus random source
// --------------------------------------------------
function automatic int unsigned lcg_draw(input int unsigned n);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % n;   // Upper bits are the better ones
endfunction

// --------------------------------------------------
// Reference model of one burst
// --------------------------------------------------
function automatic logic [`AXI_ADDR_W-1:0] ref_beat_addr(input axi_rd_pkg::ar_req_t req,
                                                         input int k);
    int bytes;
    int span;
    int start;
    int base;
    int a;
    bytes = 1 << req.size;
    span  = (int'(req.len) + 1) * bytes;   // Wrap window in bytes
    start = int'(req.addr);
    case (req.burst)
        `AXI_BURST_FIXED: a = start;
        `AXI_BURST_INCR:  a = (k == 0) ? start : (start / bytes) * bytes + k * bytes;
        `AXI_BURST_WRAP: begin
            base = (start / span) * span;
            a    = base + ((start - base + k * bytes) % span);
        end
        default: a = start;
    endcase
    return `AXI_ADDR_W'(a);   // Address space wraps at 64 KiB
endfunction

function automatic axi_rd_pkg::r_beat_t ref_beat(input axi_rd_pkg::ar_req_t req, input int k);
    axi_rd_pkg::r_beat_t beat;
    logic [`AXI_ADDR_W-1:0] addr;
    addr      = ref_beat_addr(req, k);
    beat.id   = req.id;
    beat.data = `AXI_DATA_W'({req.id, addr});
    beat.last = (k == int'(req.len));
    beat.resp = (beat.last && req.id == {`AXI_ID_W{1'b1}}) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    return beat;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_beat(input axi_rd_pkg::r_beat_t got, input axi_rd_pkg::r_beat_t exp,
                          input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got id=%h data=%h resp=%0d last=%b", $time, what,
                 got.id, got.data, got.resp, got.last);
        $display("MISMATCH at %0t: %s expected id=%h data=%h resp=%0d last=%b", $time, what,
                 exp.id, exp.data, exp.resp, exp.last);
        fail_run();
    end
endtask

task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t: %s got ar_ready=%b expected %b", $time, what, got, exp);
        fail_run();
    end
endtask

task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("MISMATCH at %0t: %s got %0d cycles expected %0d", $time, what, got, exp);
        fail_run();
    end
endtask

`endif

/* bench/tb_axi_rd_slave.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module tb_axi_rd_slave;

    localparam int OST_DEPTH   = 4;
    localparam int N_RAND      = 40;
    localparam int N_REQ       = 1 + OST_DEPTH + N_RAND;
    localparam int TIMEOUT_CYC = N_REQ * (`RD_MAX_BEATS * `RD_FETCH_DELAY + 20);

    logic                clk;
    logic                rst_n;
    axi_rd_pkg::ar_req_t ar;
    logic                ar_valid;
    logic                ar_ready;
    axi_rd_pkg::r_beat_t r;
    logic                r_valid;
    logic                r_ready;

    int unsigned         lcg_state = 52348;
    axi_rd_pkg::r_beat_t exp_q [$];          // Expected beats in request order
    logic                ready_pat [256];
    int                  ready_mode = 0;     // 0 low, 1 high, 2 pattern
    int                  pat_idx    = 0;
    int                  last_count = 0;     // Last beats seen on R
    logic                stalled    = 1'b0;
    axi_rd_pkg::r_beat_t stall_beat;

    task automatic fail_run();
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    `include "tb_axi_rd_model.svh"

    axi_rd_slave #(.OST_DEPTH(OST_DEPTH)) dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles", TIMEOUT_CYC);
        fail_run();
    end

    always @(negedge clk) begin
        case (ready_mode)
            0:       r_ready = 1'b0;
            1:       r_ready = 1'b1;
            default: begin
                r_ready = ready_pat[pat_idx];
                pat_idx = (pat_idx + 1) % 256;
            end
        endcase
    end

    // --------------------------------------------------
    // Monitor and checker
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (ar_valid && ar_ready) begin
                for (int k = 0; k <= int'(ar.len); k++) begin
                    exp_q.push_back(ref_beat(ar, k));
                end
            end
            if (stalled) begin   // AXI hold rule on R
                if (!r_valid) begin
                    $display("ERROR: r_valid dropped at %0t before its beat transferred", $time);
                    fail_run();
                end else begin
                    check_beat(r, stall_beat, "R payload changed while stalled");
                end
            end
            if (r_valid && r_ready) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: R beat at %0t with no outstanding request", $time);
                    fail_run();
                end else begin
                    check_beat(r, exp_q[0], "R beat");
                    void'(exp_q.pop_front());
                    if (r.last) last_count++;
                end
            end
            stalled    = r_valid && !r_ready;
            stall_beat = r;
        end
    end

    function automatic axi_rd_pkg::ar_req_t random_req();
        axi_rd_pkg::ar_req_t req;
        req.id    = (lcg_draw(4) == 0) ? {`AXI_ID_W{1'b1}} : `AXI_ID_W'(lcg_draw(16));
        req.burst = `AXI_BURST_W'(lcg_draw(3));
        req.size  = `AXI_SIZE_W'(lcg_draw(3));
        req.addr  = `AXI_ADDR_W'(lcg_draw(65536));
        if (req.burst == `AXI_BURST_WRAP) begin
            req.len  = `AXI_LEN_W'((2 << lcg_draw(3)) - 1);   // 2, 4 or 8 beats
            req.addr = req.addr & ~((`AXI_ADDR_W'(1) << req.size) - `AXI_ADDR_W'(1));
        end else begin
            req.len = `AXI_LEN_W'(lcg_draw(8));
        end
        return req;
    endfunction

    // Entered on a falling edge, leaves on the one after the transfer
    task automatic send_req(input axi_rd_pkg::ar_req_t req, input int gap);
        repeat (gap) @(negedge clk);
        ar       = req;
        ar_valid = 1'b1;
        do @(posedge clk); while (!ar_ready);
        @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;   // Applied at the next falling edge
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        axi_rd_pkg::ar_req_t req;
        int                  cycles;
        int                  gap;
        int                  lasts_before;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        rst_n    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_ready(ar_ready, 1'b1, "after reset");
        if (r_valid !== 1'b0) begin
            $display("ERROR: r_valid is high right after reset");
            fail_run();
        end

        // First-beat latency on an empty ring
        set_ready_mode(1);
        @(negedge clk);
        req = '{id: 4'h5, addr: 16'h1232, len: 3'd3, size: 3'd2, burst: `AXI_BURST_INCR};
        send_req(req, 0);
        cycles = 0;
        while (!r_valid) begin
            @(negedge clk);
            cycles++;
        end
        check_cycles(cycles, `RD_FETCH_DELAY, "first-beat latency");
        wait_drained();

        // Fill every slot with R stalled
        set_ready_mode(0);
        @(negedge clk);
        for (int i = 0; i < OST_DEPTH; i++) begin
            req = random_req();
            send_req(req, 0);
        end
        check_ready(ar_ready, 1'b0, "all slots busy");
        repeat (`RD_MAX_BEATS * `RD_FETCH_DELAY + 10) begin
            @(negedge clk);
            check_ready(ar_ready, 1'b0, "all slots busy with R stalled");
        end
        lasts_before = last_count;
        set_ready_mode(1);
        do begin   // Ready only once the oldest burst is gone
            @(negedge clk);
            check_ready(ar_ready, last_count > lasts_before, "while oldest burst drains");
        end while (!ar_ready);
        wait_drained();

        // Random traffic with random R back-pressure
        for (int i = 0; i < 256; i++) begin
            ready_pat[i] = (lcg_draw(4) != 0);
        end
        set_ready_mode(2);
        @(negedge clk);
        for (int i = 0; i < N_RAND; i++) begin
            req = random_req();
            gap = int'(lcg_draw(4));
            send_req(req, gap);
        end
        wait_drained();
        @(negedge clk);

        if (exp_q.size() == 0 && ar_ready && !r_valid) begin
            $display("test passed");
            $finish;
        end else begin
            $display("ERROR: DUT not idle at end of run");
            fail_run();
        end
    end

endmodule

/* hw/axi_rd_slave.sv */
`timescale 1ns/1ps

module axi_rd_slave #(
    parameter int OST_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,

    // AR channel
    input  axi_rd_pkg::ar_req_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,

    // R channel
    output axi_rd_pkg::r_beat_t r,
    output logic                r_valid,
    input  logic                r_ready
);

    logic [OST_DEPTH-1:0]   slot_busy;
    logic [OST_DEPTH-1:0]   slot_load;
    logic [OST_DEPTH-1:0]   slot_take;
    axi_rd_pkg::ar_req_t    load_req;
    axi_rd_pkg::slot_head_t slot_heads [OST_DEPTH];

    // --------------------------------------------------
    // Request side
    // --------------------------------------------------
    ar_alloc #(
        .OST_DEPTH (OST_DEPTH)
    ) u_ar_alloc (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .busy     (slot_busy),
        .load     (slot_load),
        .load_req (load_req)
    );

    // --------------------------------------------------
    // Outstanding transaction slots
    // --------------------------------------------------
    for (genvar i = 0; i < OST_DEPTH; i++) begin : g_slot
        rd_slot u_rd_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (slot_load[i]),
            .load_req (load_req),
            .take     (slot_take[i]),
            .busy     (slot_busy[i]),
            .head     (slot_heads[i])
        );
    end

    // In-order drain onto R
    r_return #(
        .OST_DEPTH (OST_DEPTH)
    ) u_r_return (
        .clk     (clk),
        .rst_n   (rst_n),
        .heads   (slot_heads),
        .take    (slot_take),
        .r       (r),
        .r_valid (r_valid),
        .r_ready (r_ready)
    );

endmodule

/* hw/r_return.sv */
`timescale 1ns/1ps

module r_return #(
    parameter int OST_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Slot ring
    input  axi_rd_pkg::slot_head_t heads [OST_DEPTH],
    output logic [OST_DEPTH-1:0]   take,

    // R channel
    output axi_rd_pkg::r_beat_t    r,
    output logic                   r_valid,
    input  logic                   r_ready
);

    localparam int PTR_W = $clog2(OST_DEPTH);

    logic [PTR_W-1:0] res_ptr;   // Oldest outstanding slot
    logic             r_fire;

    // --------------------------------------------------
    // Head mux onto R
    // --------------------------------------------------
    assign r       = heads[res_ptr].beat;
    assign r_valid = heads[res_ptr].valid;
    assign r_fire  = r_valid & r_ready;

    always_comb begin
        take = '0;
        if (r_fire) begin
            take[res_ptr] = 1'b1;   // Slot moves to its next beat
        end
    end

    // --------------------------------------------------
    // Result pointer
    // --------------------------------------------------
    // Moves only after the final beat, which keeps
    // transactions in request order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_ptr <= '0;
        end else if (r_fire && r.last) begin
            if (res_ptr == PTR_W'(OST_DEPTH - 1)) begin
                res_ptr <= '0;
            end else begin
                res_ptr <= res_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/rd_slot.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module rd_slot (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  axi_rd_pkg::ar_req_t    load_req,
    input  logic                   take,
    output logic                   busy,
    output axi_rd_pkg::slot_head_t head
);

    localparam int DLY_W = $clog2(`RD_FETCH_DELAY);
    localparam int IDX_W = `AXI_LEN_W;
    localparam int PAD_W = `AXI_DATA_W - `AXI_ID_W - `AXI_ADDR_W;

    axi_rd_pkg::ar_req_t    req_q;
    axi_rd_pkg::ar_req_t    gen_req;
    logic                   fetching;    // Beats still to fetch
    logic [DLY_W-1:0]       dly_cnt;
    logic                   fetch;       // One beat lands this edge
    logic [IDX_W-1:0]       fetch_idx;
    logic [IDX_W-1:0]       rd_idx;      // Next beat for return side
    logic [`RD_MAX_BEATS-1:0] beat_vld;
    logic [`AXI_DATA_W-1:0] beat_data [`RD_MAX_BEATS];
    logic [`AXI_ADDR_W-1:0] beat_addr;
    logic                   rd_last;

    // --------------------------------------------------
    // Request capture and address sequencing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= load_req;
        end
    end

    // Generator sees the new request during the load cycle
    assign gen_req = load ? load_req : req_q;

    burst_addr_gen u_addr_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .start (load),
        .req   (gen_req),
        .step  (fetch),
        .addr  (beat_addr)
    );

    // --------------------------------------------------
    // Fetch timer
    // --------------------------------------------------
    assign fetch = fetching && (dly_cnt == DLY_W'(`RD_FETCH_DELAY - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetching  <= 1'b0;
            dly_cnt   <= '0;
            fetch_idx <= '0;
        end else if (load) begin
            fetching  <= 1'b1;
            dly_cnt   <= '0;
            fetch_idx <= '0;
        end else if (fetch) begin
            dly_cnt   <= '0;
            fetch_idx <= fetch_idx + 1'b1;
            if (fetch_idx == req_q.len) begin
                fetching <= 1'b0;   // Last beat fetched
            end
        end else if (fetching) begin
            dly_cnt <= dly_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Beat buffer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (fetch) begin
            beat_data[fetch_idx] <= {{PAD_W{1'b0}}, req_q.id, beat_addr};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_vld <= '0;
        end else if (load) begin
            beat_vld <= '0;
        end else if (fetch) begin
            beat_vld[fetch_idx] <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Read-out and slot lifetime
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rd_idx <= '0;
        end else if (load) begin
            busy   <= 1'b1;
            rd_idx <= '0;
        end else if (take) begin
            rd_idx <= rd_idx + 1'b1;
            if (rd_last) begin
                busy <= 1'b0;   // Free once the final beat leaves
            end
        end
    end

    assign rd_last = (rd_idx == req_q.len);

    always_comb begin
        head            = '0;
        head.valid      = busy & beat_vld[rd_idx];
        head.beat.id    = req_q.id;
        head.beat.data  = beat_data[rd_idx];
        head.beat.last  = rd_last;
        head.beat.resp  = (rd_last && (&req_q.id)) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    end

endmodule

/* hw/burst_addr_gen.sv */
`timescale 1ns/1ps
`include "axi_rd_defines.svh"

module burst_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,   // Load a new burst
    input  axi_rd_pkg::ar_req_t    req,
    input  logic                   step,    // Advance to next beat
    output logic [`AXI_ADDR_W-1:0] addr
);

    localparam int AW = `AXI_ADDR_W;

    logic [AW-1:0] num_bytes;
    logic [AW-1:0] burst_beats;
    logic [AW-1:0] wrap_span;
    logic [AW-1:0] wrap_base;
    logic [AW-1:0] aligned_addr;
    logic [AW-1:0] seq_addr;
    logic [AW-1:0] next_addr;
    logic          at_top;
    logic          wrapped;

    // --------------------------------------------------
    // Burst geometry
    // --------------------------------------------------
    assign num_bytes   = AW'(1) << req.size;
    assign burst_beats = AW'(req.len) + AW'(1);
    assign wrap_span   = burst_beats << req.size;          // Window size in bytes
    assign wrap_base   = req.addr & ~(wrap_span - AW'(1)); // Power-of-two window

    // First INCR step also aligns an unaligned start address
    assign aligned_addr = addr & ~(num_bytes - AW'(1));
    assign seq_addr     = aligned_addr + num_bytes;
    assign at_top       = (seq_addr == wrap_base + wrap_span);

    always_comb begin
        case (req.burst)
            `AXI_BURST_FIXED: begin
                next_addr = addr;
            end
            `AXI_BURST_INCR: begin
                next_addr = seq_addr;
            end
            `AXI_BURST_WRAP: begin
                // A burst wraps at most once inside its window
                if (!wrapped && at_top) begin
                    next_addr = wrap_base;
                end else begin
                    next_addr = seq_addr;
                end
            end
            default: begin
                next_addr = addr;   // Reserved type holds
            end
        endcase
    end

    // --------------------------------------------------
    // Current beat address
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr    <= '0;
            wrapped <= 1'b0;
        end else if (start) begin
            addr    <= req.addr;
            wrapped <= 1'b0;
        end else if (step) begin
            addr <= next_addr;
            if (req.burst == `AXI_BURST_WRAP && at_top) begin
                wrapped <= 1'b1;
            end
        end
    end

endmodule

/* hw/ar_alloc.sv */
`timescale 1ns/1ps

module ar_alloc #(
    parameter int OST_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // AR channel
    input  axi_rd_pkg::ar_req_t  ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,

    // Slot ring
    input  logic [OST_DEPTH-1:0] busy,
    output logic [OST_DEPTH-1:0] load,
    output axi_rd_pkg::ar_req_t  load_req
);

    localparam int PTR_W = $clog2(OST_DEPTH);

    logic [PTR_W-1:0] set_ptr;   // Next slot to fill
    logic             ar_fire;

    // --------------------------------------------------
    // Readiness and load strobe
    // --------------------------------------------------
    // Slots drain in order, so only the pointed slot matters
    assign ar_ready = ~busy[set_ptr];
    assign ar_fire  = ar_valid & ar_ready;

    always_comb begin
        load = '0;
        if (ar_fire) begin
            load[set_ptr] = 1'b1;   // One-hot to the chosen slot
        end
    end

    assign load_req = ar;   // Slot captures at the load edge

    // --------------------------------------------------
    // Set pointer
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            set_ptr <= '0;
        end else if (ar_fire) begin
            if (set_ptr == PTR_W'(OST_DEPTH - 1)) begin
                set_ptr <= '0;   // Wrap for any depth
            end else begin
                set_ptr <= set_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/axi_rd_pkg.sv */
`include "axi_rd_defines.svh"

package axi_rd_pkg;

    // --------------------------------------------------
    // AR channel payload
    // --------------------------------------------------
    typedef struct packed {
        logic [`AXI_ID_W-1:0]    id;
        logic [`AXI_ADDR_W-1:0]  addr;
        logic [`AXI_LEN_W-1:0]   len;      // Beats minus one
        logic [`AXI_SIZE_W-1:0]  size;     // Log2 of bytes per beat
        logic [`AXI_BURST_W-1:0] burst;
    } ar_req_t;

    // --------------------------------------------------
    // R channel payload
    // --------------------------------------------------
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_RESP_W-1:0] resp;
        logic                   last;
    } r_beat_t;

    // --------------------------------------------------
    // Slot to return stage
    // --------------------------------------------------
    // valid means the beat at the read index is fetched
    // and has not been taken yet
    typedef struct packed {
        logic    valid;
        r_beat_t beat;
    } slot_head_t;

endpackage

/* hw/axi_rd_defines.svh */
`ifndef AXI_RD_DEFINES_SVH
`define AXI_RD_DEFINES_SVH

// --------------------------------------------------
// AXI read channel field widths
// --------------------------------------------------
`define AXI_ID_W        4
`define AXI_ADDR_W      16
`define AXI_DATA_W      32
`define AXI_LEN_W       3
`define AXI_SIZE_W      3
`define AXI_BURST_W     2
`define AXI_RESP_W      2

// --------------------------------------------------
// Burst and response encodings
// --------------------------------------------------
`define AXI_BURST_FIXED 2'd0
`define AXI_BURST_INCR  2'd1
`define AXI_BURST_WRAP  2'd2

`define AXI_RESP_OKAY   2'd0
`define AXI_RESP_SLVERR 2'd2

// --------------------------------------------------
// Slot buffer sizing and simulated memory timing
// --------------------------------------------------
`define RD_MAX_BEATS    8       // One entry per possible beat
`define RD_FETCH_DELAY  18      // Cycles per beat fetch

`endif
